// File: filelist.f
src/bubble_pkg.sv
src/startup_ctrl.sv
src/temp_sense.sv
src/led_ctrl.sv
src/bubble_top.sv
sim/tb_bubble_top.sv

// File: sim/tb_bubble_top.sv
`timescale 1ns/1ps

module tb_bubble_top;

localparam int CLK_PERIOD   = 4;
localparam int READ_CYCLES  = 2 * bubble_pkg::TC77_BITS * bubble_pkg::SPI_DIV;
// longest wait for a read end is one period plus full warm-up plus one read
localparam int WORST_CYCLES = bubble_pkg::READ_PERIOD + 4 * bubble_pkg::WARMUP_UNIT
                              + READ_CYCLES;
localparam int NUM_TESTS    = 6;
localparam int WATCHDOG_NS  = 20 * NUM_TESTS * WORST_CYCLES * CLK_PERIOD;

logic                   MCLK;
logic                   MRST;
logic                   pwr_usb;
logic                   board_pwr_bad;
logic [3:0]             settings_sw;
bubble_pkg::delay_sel_t delay_sw;
bubble_pkg::img_num_t   img_num_sw;
logic                   force_start;
logic                   temp_so;
logic                   emu_en;
logic                   fifo_en;
logic                   mpsse_en;
logic                   bitwidth4;
logic                   bout_timing;
bubble_pkg::img_num_t   image_number;
logic                   n4ben;
logic                   temp_low;
logic                   fan_en_n;
logic                   temp_cs_n;
logic                   temp_clk;
logic                   led_pwrok_n;
logic                   led_standby_n;
logic                   led_delaying_n;

integer                 seed = 32'h4df2a616;
int                     errors = 0;
int                     tests_ok = 0;
int                     tests_bad = 0;

bubble_pkg::temp_code_t model_code;
logic [15:0]            tc77_word;
int                     tc77_idx;

bubble_top u_dut
(
    .MCLK           (MCLK),
    .MRST           (MRST),
    .pwr_usb        (pwr_usb),
    .board_pwr_bad  (board_pwr_bad),
    .settings_sw    (settings_sw),
    .delay_sw       (delay_sw),
    .img_num_sw     (img_num_sw),
    .force_start    (force_start),
    .temp_so        (temp_so),
    .emu_en         (emu_en),
    .fifo_en        (fifo_en),
    .mpsse_en       (mpsse_en),
    .bitwidth4      (bitwidth4),
    .bout_timing    (bout_timing),
    .image_number   (image_number),
    .n4ben          (n4ben),
    .temp_low       (temp_low),
    .fan_en_n       (fan_en_n),
    .temp_cs_n      (temp_cs_n),
    .temp_clk       (temp_clk),
    .led_pwrok_n    (led_pwrok_n),
    .led_standby_n  (led_standby_n),
    .led_delaying_n (led_delaying_n)
);

always #(CLK_PERIOD / 2) MCLK = ~MCLK;

////////////////////////////////////////////////////////////
// tc77 model shifting msb first on falling temp_clk
////////////////////////////////////////////////////////////

always @(negedge temp_cs_n)
begin
    // conversion done flag and two undefined bits below the code
    tc77_word = {model_code, 3'b100};
    tc77_idx  = 15;
    temp_so   = tc77_word[15];
end

always @(negedge temp_clk)
begin
    if (!temp_cs_n && tc77_idx > 0)
    begin
        tc77_idx = tc77_idx - 1;
        temp_so  = tc77_word[tc77_idx];
    end
end

////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////

task automatic cycles(input int n);
    repeat (n) @(negedge MCLK);
endtask

task automatic check_bit(input string msg, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("FAIL %0t ns: %s, got %b expected %b", $time, msg, got, exp);
        errors++;
    end
endtask

task automatic check_img(input string msg, input bubble_pkg::img_num_t got,
                         input bubble_pkg::img_num_t exp);
    if (got !== exp)
    begin
        $display("FAIL %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
        errors++;
    end
endtask

// enable set as {emu_en, fifo_en, mpsse_en}
task automatic check_state(input string msg, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
    begin
        $display("FAIL %0t ns: %s, enables got %b expected %b", $time, msg, got, exp);
        errors++;
    end
endtask

task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before)
    begin
        tests_ok++;
        $display("test %s: ok", name);
    end
    else
    begin
        tests_bad++;
        $display("test %s: %0d errors", name, errors - errs_before);
    end
endtask

// enables of the state that a {pwr_usb, board_pwr_bad} status leads to
function automatic logic [2:0] power_enables(input logic [1:0] sel);
    case (sel)
        2'b00:   return 3'b110;
        2'b11:   return 3'b001;
        default: return 3'b000;
    endcase
endfunction

function automatic bubble_pkg::temp_code_t rand_warm_code();
    return bubble_pkg::temp_code_t'(bubble_pkg::COLD_CODE + 1 + ($unsigned($random(seed))
           % (bubble_pkg::HOT_CODE - bubble_pkg::COLD_CODE - 1)));
endfunction

function automatic bubble_pkg::temp_code_t rand_cold_code();
    return bubble_pkg::temp_code_t'($unsigned($random(seed)) % bubble_pkg::COLD_CODE);
endfunction

function automatic bubble_pkg::temp_code_t rand_hot_code();
    return bubble_pkg::temp_code_t'(bubble_pkg::HOT_CODE + 1 + ($unsigned($random(seed)) % 1000));
endfunction

// reset and three more edges so the registered outputs are valid
task automatic reset_dut(input logic usb, input logic bad);
    MRST          = 1'b1;
    pwr_usb       = usb;
    board_pwr_bad = bad;
    cycles(3);
    MRST = 1'b0;
    cycles(3);
endtask

// returns on the falling edge after temp_cs_n rises
task automatic wait_read();
    int n;
    n = 0;
    while (temp_cs_n === 1'b1 && n < WORST_CYCLES)
    begin
        cycles(1);
        n++;
    end
    while (temp_cs_n === 1'b0 && n < WORST_CYCLES)
    begin
        cycles(1);
        n++;
    end
    if (n >= WORST_CYCLES)
    begin
        $display("error at %0t ns: no sensor read finished within %0d cycles", $time, n);
        errors++;
    end
endtask

task automatic measure_warmup(output int len);
    len = 0;
    while (led_delaying_n === 1'b0 && len < WORST_CYCLES)
    begin
        check_bit("emu_en during warm-up", emu_en, 1'b0);
        check_bit("fifo_en during warm-up", fifo_en, 1'b0);
        cycles(1);
        len++;
    end
endtask

// cycles until led_pwrok_n changes
task automatic wait_toggle(output int n);
    logic prev;
    prev = led_pwrok_n;
    n = 0;
    while (led_pwrok_n === prev && n < 4 * bubble_pkg::BLINK_HALF)
    begin
        cycles(1);
        n++;
    end
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////

task automatic power_eval_test();
    int         errs;
    logic [1:0] sel;
    logic [1:0] next_sel;
    errs = errors;
    for (int i = 0; i < 4; i++)
    begin
        sel = i[1:0];
        reset_dut(sel[1], sel[0]);
        if (sel == 2'b00)
            check_bit("mpsse_en in emulator mode", mpsse_en, 1'b0);
        else
        begin
            repeat (8)
            begin
                check_state($sformatf("power status %b", sel),
                            {emu_en, fifo_en, mpsse_en}, power_enables(sel));
                cycles(1);
            end
            // leaving the condition goes back through st_reset
            next_sel = sel ^ 2'b01;
            {pwr_usb, board_pwr_bad} = next_sel;
            cycles(2);
            check_state($sformatf("leaving power status %b", sel),
                        {emu_en, fifo_en, mpsse_en}, 3'b000);
            // then on through st_eval into the new target state
            cycles(2);
            check_state($sformatf("re-entry from %b into power status %b", sel, next_sel),
                        {emu_en, fifo_en, mpsse_en}, power_enables(next_sel));
        end
    end
    report_test("power_eval", errs);
endtask

task automatic switch_latch_test();
    int                   errs;
    logic [3:0]           sw;
    bubble_pkg::img_num_t exp_img;
    errs = errors;
    model_code  = rand_warm_code();
    settings_sw = 4'($random(seed));
    img_num_sw  = 3'($random(seed));
    delay_sw    = 2'($random(seed));
    sw          = settings_sw;
    exp_img     = ~img_num_sw;
    reset_dut(1'b0, 1'b0);
    check_img("image_number after latch", image_number, exp_img);
    check_bit("bitwidth4 after latch", bitwidth4, ~sw[3]);
    check_bit("bout_timing after latch", bout_timing, ~sw[2]);
    // later switch changes are ignored
    settings_sw = ~settings_sw;
    img_num_sw  = ~img_num_sw;
    cycles(8);
    check_img("image_number after switch change", image_number, exp_img);
    check_bit("bitwidth4 after switch change", bitwidth4, ~sw[3]);
    check_bit("bout_timing after switch change", bout_timing, ~sw[2]);
    check_bit("n4ben follows the switch", n4ben, ~sw[3]);
    check_state("emulator enables", {emu_en, fifo_en, mpsse_en}, 3'b110);
    report_test("switch_latch", errs);
endtask

task automatic warm_start_test();
    int errs;
    errs = errors;
    settings_sw = 4'hf;
    model_code  = rand_warm_code();
    reset_dut(1'b0, 1'b0);
    wait_read();
    cycles(1);
    check_bit("temp_low after warm read", temp_low, 1'b0);
    repeat (16)
    begin
        check_bit("led_delaying_n with warm sensor", led_delaying_n, 1'b1);
        check_state("enables with warm sensor", {emu_en, fifo_en, mpsse_en}, 3'b110);
        cycles(1);
    end
    report_test("warm_start", errs);
endtask

task automatic cold_delay_test();
    int                     errs;
    int                     len;
    int                     exp_len;
    bubble_pkg::delay_sel_t d;
    errs = errors;
    settings_sw = 4'hf;
    delay_sw    = 2'($random(seed));
    d           = ~delay_sw;
    exp_len     = (int'(d) + 1) * bubble_pkg::WARMUP_UNIT;
    model_code  = rand_cold_code();
    reset_dut(1'b0, 1'b0);
    wait_read();
    model_code = rand_warm_code();
    cycles(1);
    check_bit("temp_low after cold read", temp_low, 1'b1);
    check_bit("led_delaying_n at warm-up start", led_delaying_n, 1'b0);
    check_bit("led_standby_n at warm-up start", led_standby_n, 1'b0);
    measure_warmup(len);
    check_bit($sformatf("warm-up of %0d cycles, expected %0d", len, exp_len),
              (len >= exp_len - 2 * bubble_pkg::SPI_DIV) &&
              (len <= exp_len + 2 * bubble_pkg::SPI_DIV), 1'b1);
    wait_read();
    cycles(1);
    check_bit("temp_low after warm re-read", temp_low, 1'b0);
    check_state("enables after warm-up", {emu_en, fifo_en, mpsse_en}, 3'b110);
    check_bit("led_standby_n after warm-up", led_standby_n, 1'b1);

    // force_start cuts the longest delay short
    delay_sw   = 2'b00;
    model_code = rand_cold_code();
    reset_dut(1'b0, 1'b0);
    wait_read();
    model_code = rand_warm_code();
    cycles(20);
    check_bit("led_delaying_n before force_start", led_delaying_n, 1'b0);
    force_start = 1'b1;
    cycles(1);
    force_start = 1'b0;
    check_bit("led_delaying_n after force_start", led_delaying_n, 1'b1);
    check_bit("emu_en after force_start", emu_en, 1'b1);
    wait_read();
    cycles(1);
    check_bit("temp_low after forced start", temp_low, 1'b0);
    report_test("cold_delay", errs);
endtask

task automatic fan_test();
    int   errs;
    logic allow;
    errs = errors;
    for (int i = 0; i < 2; i++)
    begin
        allow       = (i == 0);
        settings_sw = {3'b111, ~allow};
        model_code  = rand_hot_code();
        reset_dut(1'b0, 1'b0);
        wait_read();
        cycles(1);
        check_bit($sformatf("fan_en_n after hot read, fan_allow %b", allow), fan_en_n, ~allow);
        // next periodic read is normal
        if (allow)
        begin
            model_code = rand_warm_code();
            wait_read();
            cycles(1);
            check_bit("fan_en_n after normal read", fan_en_n, 1'b1);
        end
    end
    report_test("fan", errs);
endtask

task automatic led_blink_test();
    int         errs;
    int         n;
    logic [1:0] sel;
    errs = errors;
    model_code = rand_warm_code();
    for (int i = 1; i < 3; i++)
    begin
        sel = i[1:0];
        reset_dut(sel[1], sel[0]);
        wait_toggle(n);
        wait_toggle(n);
        check_bit($sformatf("blink half period %0d in state %b", n, sel),
                  n == bubble_pkg::BLINK_HALF, 1'b1);
    end
    reset_dut(1'b0, 1'b0);
    repeat (2 * bubble_pkg::BLINK_HALF + 8)
    begin
        check_bit("led_pwrok_n steady in emulator mode", led_pwrok_n, 1'b0);
        cycles(1);
    end
    report_test("led_blink", errs);
endtask

////////////////////////////////////////////////////////////
// main sequence and watchdog
////////////////////////////////////////////////////////////

initial
begin
    MCLK          = 1'b0;
    MRST          = 1'b1;
    pwr_usb       = 1'b0;
    board_pwr_bad = 1'b0;
    settings_sw   = 4'hf;
    delay_sw      = 2'b11;
    img_num_sw    = 3'b111;
    force_start   = 1'b0;
    temp_so       = 1'b0;
    model_code    = 13'd320;
    tc77_word     = '0;
    tc77_idx      = 0;
    @(negedge MCLK);

    power_eval_test();
    switch_latch_test();
    warm_start_test();
    cold_delay_test();
    fan_test();
    led_blink_test();

    $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
    if (errors == 0)
        $display(">>> PASS");
    else
        $display(">>> FAIL");
    $finish;
end

initial
begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
end

endmodule

// File: src/bubble_top.sv
`timescale 1ns/1ps

module bubble_top
(
    input  logic                    MCLK,
    input  logic                    MRST,

    // board inputs
    input  logic                    pwr_usb,
    input  logic                    board_pwr_bad,
    input  logic [3:0]              settings_sw,
    input  bubble_pkg::delay_sel_t  delay_sw,
    input  bubble_pkg::img_num_t    img_num_sw,
    input  logic                    force_start,
    input  logic                    temp_so,

    // enables and settings for the cores
    output logic                    emu_en,
    output logic                    fifo_en,
    output logic                    mpsse_en,
    output logic                    bitwidth4,
    output logic                    bout_timing,
    output bubble_pkg::img_num_t    image_number,
    output logic                    n4ben,

    // sensor and fan
    output logic                    temp_low,
    output logic                    fan_en_n,
    output logic                    temp_cs_n,
    output logic                    temp_clk,

    // leds
    output logic                    led_pwrok_n,
    output logic                    led_standby_n,
    output logic                    led_delaying_n
);

logic                   temp_en;
logic                   req_delaying;
logic                   req_pwrok;
logic                   req_standby;
logic                   blink_run;
logic                   fan_allow;
logic                   warming;
bubble_pkg::delay_sel_t delay_sel;

// 4-bit mode strap goes straight to the cartridge
assign n4ben = settings_sw[3];

startup_ctrl u_startup
(
    .MCLK           (MCLK),
    .MRST           (MRST),
    .pwr_usb        (pwr_usb),
    .board_pwr_bad  (board_pwr_bad),
    .settings_sw    (settings_sw),
    .delay_sw       (delay_sw),
    .img_num_sw     (img_num_sw),
    .warming        (warming),
    .emu_en         (emu_en),
    .fifo_en        (fifo_en),
    .mpsse_en       (mpsse_en),
    .temp_en        (temp_en),
    .req_delaying   (req_delaying),
    .req_pwrok      (req_pwrok),
    .req_standby    (req_standby),
    .blink_run      (blink_run),
    .bitwidth4      (bitwidth4),
    .bout_timing    (bout_timing),
    .fan_allow      (fan_allow),
    .delay_sel      (delay_sel),
    .image_number   (image_number)
);

temp_sense u_temp
(
    .MCLK           (MCLK),
    .MRST           (MRST),
    .temp_en        (temp_en),
    .delay_sel      (delay_sel),
    .fan_allow      (fan_allow),
    .force_start    (force_start),
    .temp_so        (temp_so),
    .temp_cs_n      (temp_cs_n),
    .temp_clk       (temp_clk),
    .temp_low       (temp_low),
    .warming        (warming),
    .fan_en_n       (fan_en_n)
);

led_ctrl u_led
(
    .MCLK           (MCLK),
    .MRST           (MRST),
    .blink_run      (blink_run),
    .req_delaying   (req_delaying),
    .req_pwrok      (req_pwrok),
    .req_standby    (req_standby),
    .warming        (warming),
    .led_pwrok_n    (led_pwrok_n),
    .led_standby_n  (led_standby_n),
    .led_delaying_n (led_delaying_n)
);

endmodule

// File: src/led_ctrl.sv
`timescale 1ns/1ps

module led_ctrl
(
    input  logic    MCLK,
    input  logic    MRST,

    input  logic    blink_run,
    input  logic    req_delaying,
    input  logic    req_pwrok,
    input  logic    req_standby,
    input  logic    warming,

    // active low
    output logic    led_pwrok_n,
    output logic    led_standby_n,
    output logic    led_delaying_n
);

logic [bubble_pkg::BLINK_CNT_W-1:0] blink_cnt;
logic                               blinker;

////////////////////////////////////////////////////////////
// blinker, idles high (led off)
////////////////////////////////////////////////////////////

always_ff @(posedge MCLK)
begin
    if (MRST || !blink_run)
    begin
        blink_cnt <= '0;
        blinker   <= 1'b1;
    end
    else if (blink_cnt == bubble_pkg::BLINK_CNT_W'(bubble_pkg::BLINK_HALF - 1))
    begin
        blink_cnt <= '0;
        blinker   <= ~blinker;
    end
    else
    begin
        blink_cnt <= blink_cnt + 1'b1;
    end
end

////////////////////////////////////////////////////////////
// led drive
////////////////////////////////////////////////////////////

// steady when powered ok, flashing in standby/error
assign led_pwrok_n    = ~req_pwrok & blinker;

// standby flashes, warm-up lights it steadily
assign led_standby_n  = ~((req_standby & ~blinker) | warming);

assign led_delaying_n = ~(req_delaying & warming);

endmodule

// File: src/temp_sense.sv
`timescale 1ns/1ps

module temp_sense
(
    input  logic                    MCLK,
    input  logic                    MRST,

    input  logic                    temp_en,
    input  bubble_pkg::delay_sel_t  delay_sel,
    input  logic                    fan_allow,
    input  logic                    force_start,

    // tc77 pins
    input  logic                    temp_so,
    output logic                    temp_cs_n,
    output logic                    temp_clk,

    output logic                    temp_low,
    output logic                    warming,
    output logic                    fan_en_n
);

typedef enum logic [1:0] {
    ts_idle,
    ts_shift,
    ts_wait,
    ts_warm
} ts_state_t;

ts_state_t                                  state;
logic [bubble_pkg::DIV_CNT_W-1:0]           div_cnt;
logic [bubble_pkg::BIT_CNT_W-1:0]           bit_cnt;
logic [bubble_pkg::PERIOD_CNT_W-1:0]        period_cnt;
logic [bubble_pkg::WARM_CNT_W-1:0]          warm_cnt;
logic [bubble_pkg::TC77_BITS-1:0]           shreg;
logic                                       read_done;
logic                                       start_rd;
bubble_pkg::temp_code_t                     rd_code;
logic                                       is_cold;
logic                                       is_hot;

// upper 13 bits hold the temperature, the rest are status
assign rd_code = shreg[bubble_pkg::TC77_BITS-1 -: $bits(bubble_pkg::temp_code_t)];
assign is_cold = $signed(rd_code) < bubble_pkg::COLD_CODE;
assign is_hot  = $signed(rd_code) > bubble_pkg::HOT_CODE;

// new read: on enable, on period expiry, or when warm-up ends
assign start_rd = (state == ts_idle) ||
                  (state == ts_wait && !read_done &&
                   period_cnt == bubble_pkg::PERIOD_CNT_W'(bubble_pkg::READ_PERIOD - 1)) ||
                  (state == ts_warm &&
                   (warm_cnt == bubble_pkg::WARM_CNT_W'(1) || force_start));

////////////////////////////////////////////////////////////
// sensor read sequencer
////////////////////////////////////////////////////////////

always_ff @(posedge MCLK)
begin
    if (MRST || !temp_en)
    begin
        state      <= ts_idle;
        temp_cs_n  <= 1'b1;
        temp_clk   <= 1'b0;
        div_cnt    <= '0;
        bit_cnt    <= '0;
        period_cnt <= '0;
        warm_cnt   <= '0;
        read_done  <= 1'b0;
        temp_low   <= 1'b0;
        warming    <= 1'b0;
        fan_en_n   <= 1'b1;
    end
    else if (start_rd)
    begin
        state      <= ts_shift;
        temp_cs_n  <= 1'b0;
        div_cnt    <= '0;
        bit_cnt    <= '0;
        period_cnt <= '0;
        warming    <= 1'b0;
    end
    else
    begin
        read_done <= 1'b0;
        case (state)
            ts_shift:
            begin
                period_cnt <= period_cnt + 1'b1;
                if (div_cnt == bubble_pkg::DIV_CNT_W'(bubble_pkg::SPI_DIV - 1))
                begin
                    div_cnt  <= '0;
                    temp_clk <= ~temp_clk;
                    // rising edge of temp_clk, msb first
                    if (!temp_clk)
                        shreg <= {shreg[bubble_pkg::TC77_BITS-2:0], temp_so};
                    else if (bit_cnt == bubble_pkg::BIT_CNT_W'(bubble_pkg::TC77_BITS - 1))
                    begin
                        temp_cs_n <= 1'b1;
                        read_done <= 1'b1;
                        state     <= ts_wait;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                else
                    div_cnt <= div_cnt + 1'b1;
            end

            ts_wait:
            begin
                period_cnt <= period_cnt + 1'b1;
                // evaluate the finished read
                if (read_done)
                begin
                    temp_low <= is_cold;
                    fan_en_n <= ~(fan_allow & is_hot);
                    if (is_cold)
                    begin
                        warming  <= 1'b1;
                        warm_cnt <= bubble_pkg::WARM_CNT_W'(
                                    (int'(delay_sel) + 1) * bubble_pkg::WARMUP_UNIT);
                        state    <= ts_warm;
                    end
                end
            end

            ts_warm:
                warm_cnt <= warm_cnt - 1'b1;

            default:
                state <= ts_idle;
        endcase
    end
end

endmodule

// File: src/startup_ctrl.sv
`timescale 1ns/1ps

module startup_ctrl
(
    input  logic                    MCLK,
    input  logic                    MRST,

    // power status
    input  logic                    pwr_usb,
    input  logic                    board_pwr_bad,

    // active-low dip switches
    input  logic [3:0]              settings_sw,
    input  bubble_pkg::delay_sel_t  delay_sw,
    input  bubble_pkg::img_num_t    img_num_sw,

    input  logic                    warming,

    // block enables
    output logic                    emu_en,
    output logic                    fifo_en,
    output logic                    mpsse_en,
    output logic                    temp_en,

    // led requests
    output logic                    req_delaying,
    output logic                    req_pwrok,
    output logic                    req_standby,
    output logic                    blink_run,

    // latched settings
    output logic                    bitwidth4,
    output logic                    bout_timing,
    output logic                    fan_allow,
    output bubble_pkg::delay_sel_t  delay_sel,
    output bubble_pkg::img_num_t    image_number
);

bubble_pkg::sup_state_t state;
logic [1:0]             pwr_sel;
logic                   run_req;

assign pwr_sel = {pwr_usb, board_pwr_bad};

////////////////////////////////////////////////////////////
// state flow
////////////////////////////////////////////////////////////

always_ff @(posedge MCLK)
begin
    if (MRST)
    begin
        state <= bubble_pkg::st_reset;
    end
    else
    begin
        case (state)
            bubble_pkg::st_reset:
                state <= bubble_pkg::st_eval;
            bubble_pkg::st_eval:
                case (pwr_sel)
                    2'b00:   state <= bubble_pkg::st_emulator;
                    2'b01:   state <= bubble_pkg::st_err_board;
                    2'b10:   state <= bubble_pkg::st_err_usb;
                    default: state <= bubble_pkg::st_usb_standby;
                endcase
            // emulator mode only leaves on reset
            bubble_pkg::st_emulator:
                state <= bubble_pkg::st_emulator;
            bubble_pkg::st_usb_standby:
                if (pwr_sel != 2'b11)
                    state <= bubble_pkg::st_reset;
            bubble_pkg::st_err_board:
                if (pwr_sel != 2'b01)
                    state <= bubble_pkg::st_reset;
            bubble_pkg::st_err_usb:
                if (pwr_sel != 2'b10)
                    state <= bubble_pkg::st_reset;
            default:
                state <= bubble_pkg::st_reset;
        endcase
    end
end

////////////////////////////////////////////////////////////
// registered outputs, one cycle behind the state
////////////////////////////////////////////////////////////

always_ff @(posedge MCLK)
begin
    if (MRST)
    begin
        run_req      <= 1'b0;
        mpsse_en     <= 1'b0;
        temp_en      <= 1'b0;
        req_delaying <= 1'b0;
        req_pwrok    <= 1'b0;
        req_standby  <= 1'b0;
        blink_run    <= 1'b0;
    end
    else
    begin
        run_req      <= (state == bubble_pkg::st_emulator);
        temp_en      <= (state == bubble_pkg::st_emulator);
        req_delaying <= (state == bubble_pkg::st_emulator);
        req_pwrok    <= (state == bubble_pkg::st_emulator);
        mpsse_en     <= (state == bubble_pkg::st_usb_standby);
        req_standby  <= (state == bubble_pkg::st_usb_standby);
        // standby and both error states flash the leds
        blink_run    <= (state == bubble_pkg::st_usb_standby) ||
                        (state == bubble_pkg::st_err_board) ||
                        (state == bubble_pkg::st_err_usb);
    end
end

// core and fifo wait for the sensor warm-up
assign emu_en  = run_req & ~warming;
assign fifo_en = run_req & ~warming;

// switches are sampled until st_eval is entered
always_ff @(posedge MCLK)
begin
    if (state == bubble_pkg::st_reset)
    begin
        bitwidth4    <= ~settings_sw[3];
        bout_timing  <= ~settings_sw[2];
        fan_allow    <= ~settings_sw[0];
        delay_sel    <= ~delay_sw;
        image_number <= ~img_num_sw;
    end
end

endmodule

// File: src/bubble_pkg.sv
package bubble_pkg;

    ////////////////////////////////////////////////////////////
    // data widths
    ////////////////////////////////////////////////////////////

    // tc77 reading, 0.0625 degC per lsb, two's complement
    typedef logic [12:0] temp_code_t;
    typedef logic [2:0]  img_num_t;
    typedef logic [1:0]  delay_sel_t;

    // supervisor states
    typedef enum logic [2:0] {
        st_reset,
        st_eval,
        st_emulator,
        st_usb_standby,
        st_err_board,
        st_err_usb
    } sup_state_t;

    ////////////////////////////////////////////////////////////
    // timing, all in MCLK cycles
    ////////////////////////////////////////////////////////////

    localparam int SPI_DIV     = 4;     // half period of temp_clk
    localparam int TC77_BITS   = 16;
    localparam int WARMUP_UNIT = 256;   // sim sized
    localparam int READ_PERIOD = 512;
    localparam int BLINK_HALF  = 64;

    // temperature limits in sensor lsb
    localparam int COLD_CODE = 160;     // 10 degC
    localparam int HOT_CODE  = 640;     // 40 degC

    // counter widths
    localparam int DIV_CNT_W    = $clog2(SPI_DIV);
    localparam int BIT_CNT_W    = $clog2(TC77_BITS);
    localparam int PERIOD_CNT_W = $clog2(READ_PERIOD);
    // longest warm-up is four units
    localparam int WARM_CNT_W   = $clog2(4 * WARMUP_UNIT + 1);
    localparam int BLINK_CNT_W  = $clog2(BLINK_HALF);

endpackage
